/* Makefile */
# Verilator build and run of the cpu testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu

# the run fails unless the pass line shows up in the output.
run: compile
	@out="$$(./obj_dir/tb_cpu 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* alu_compute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module alu_compute
	import cpu_data_pkg::*;
	import cpu_isa_pkg::*;
(
	input  word_t   a_i,
	input  word_t   b_i,
	input  opcode_e opcode_i,
	output word_t   result_o,
	output word_t   addr_o,
	output flags_t  flags_o
);

	localparam int    MSB     = `CPU_WORD_W - 1;
	localparam word_t SAT_POS = {1'b0, {MSB{1'b1}}};
	localparam word_t SAT_NEG = {1'b1, {MSB{1'b0}}};

	word_t                     sum;
	word_t                     diff;
	word_t                     sum_sat;
	word_t                     diff_sat;
	logic                      sum_ovf;
	logic                      diff_ovf;
	logic                      ovf;
	logic [3:0]                shamt;
	logic [2*`CPU_WORD_W-1:0]  rot;
	word_t                     result;

	assign sum  = a_i + b_i;
	assign diff = a_i - b_i;

	assign sum_ovf  = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
	assign diff_ovf = (a_i[MSB] != b_i[MSB]) && (diff[MSB] != a_i[MSB]);

	// clamp toward the sign of a.
	assign sum_sat  = sum_ovf ? (a_i[MSB] ? SAT_NEG : SAT_POS) : sum;
	assign diff_sat = diff_ovf ? (a_i[MSB] ? SAT_NEG : SAT_POS) : diff;

	assign shamt = b_i[3:0];
	assign rot   = {a_i, a_i} >> shamt;

	always_comb begin
		case (opcode_i)
			OP_ADD:  result = sum_sat;
			OP_SUB:  result = diff_sat;
			OP_XOR:  result = a_i ^ b_i;
			OP_SRA:  result = word_t'($signed(a_i) >>> shamt);
			OP_SLL:  result = a_i << shamt;
			OP_ROR:  result = rot[MSB:0];
			default: result = '0;
		endcase
	end

	always_comb begin
		case (opcode_i)
			OP_ADD:  ovf = sum_ovf;
			OP_SUB:  ovf = diff_ovf;
			default: ovf = 1'b0;
		endcase
	end

	assign result_o = result;

	assign flags_o[FLAG_Z] = (result == '0);
	assign flags_o[FLAG_V] = ovf;
	assign flags_o[FLAG_N] = result[MSB];

	// word aligned base plus offset in words.
	assign addr_o = {a_i[MSB:1], 1'b0} + (b_i << 1);

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu
	import cpu_data_pkg::*;
	import cpu_isa_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      imem_wr_en_i,
	input  word_t     imem_addr_i,
	input  word_t     imem_data_i,
	output word_t     pc_o,
	output logic      halt_o,
	output logic      wb_en_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o
);

	word_t      pc_q;
	word_t      pc_next;
	word_t      instr;
	flags_t     flags_q;
	flags_t     flags_d;
	mem_index_t imem_index;
	logic       imem_wr;
	logic       run;
	logic       full_flags;

	opcode_e    opcode;
	cond_e      cond;
	reg_addr_t  rs_addr;
	reg_addr_t  rt_addr;
	reg_addr_t  rd_addr;
	word_t      imm;
	imm_byte_t  byte_val;
	br_offset_t offset;
	logic       use_imm;
	logic       reg_wr;
	logic       mem_wr;
	logic       flag_wr;
	logic       dec_halt;
	wb_sel_e    wb_sel;

	word_t      rs_data;
	word_t      rt_data;
	word_t      alu_b;
	word_t      alu_result;
	word_t      mem_addr;
	flags_t     alu_flags;
	word_t      mem_rd_data;
	word_t      byte_merge;
	word_t      wb_data;

	assign run     = rst_n_i & ~dec_halt;
	assign imem_wr = imem_wr_en_i & ~rst_n_i; // loading only while in reset.

	assign imem_index = rst_n_i ? pc_q[`CPU_MEM_AW:1] : imem_addr_i[`CPU_MEM_AW:1];

	cpu_memory imem_i (
		.clk       (clk),
		.wr_en_i   (imem_wr),
		.addr_i    (imem_index),
		.wr_data_i (imem_data_i),
		.rd_data_o (instr)
	);

	instruction_decode decode_i (
		.instr_i   (instr),
		.opcode_o  (opcode),
		.cond_o    (cond),
		.rs_addr_o (rs_addr),
		.rt_addr_o (rt_addr),
		.rd_addr_o (rd_addr),
		.imm_o     (imm),
		.byte_o    (byte_val),
		.offset_o  (offset),
		.use_imm_o (use_imm),
		.reg_wr_o  (reg_wr),
		.mem_wr_o  (mem_wr),
		.flag_wr_o (flag_wr),
		.halt_o    (dec_halt),
		.wb_sel_o  (wb_sel)
	);

	register_file regs_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rs_addr_i (rs_addr),
		.rt_addr_i (rt_addr),
		.rd_addr_i (rd_addr),
		.wr_en_i   (wb_en_o),
		.rd_data_i (wb_data),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	assign alu_b = use_imm ? imm : rt_data;

	alu_compute alu_i (
		.a_i      (rs_data),
		.b_i      (alu_b),
		.opcode_i (opcode),
		.result_o (alu_result),
		.addr_o   (mem_addr),
		.flags_o  (alu_flags)
	);

	cpu_memory dmem_i (
		.clk       (clk),
		.wr_en_i   (mem_wr & run),
		.addr_i    (mem_addr[`CPU_MEM_AW:1]),
		.wr_data_i (rt_data),
		.rd_data_o (mem_rd_data)
	);

	pc_control pc_ctrl_i (
		.pc_i      (pc_q),
		.rs_data_i (rs_data),
		.offset_i  (offset),
		.opcode_i  (opcode),
		.cond_i    (cond),
		.flags_i   (flags_q),
		.pc_next_o (pc_next)
	);

	// rs holds the old destination value for byte loads.
	assign byte_merge = (opcode == OP_LHB) ? {byte_val, rs_data[7:0]} :
		{rs_data[15:8], byte_val};

	always_comb begin
		case (wb_sel)
			WB_ALU:  wb_data = alu_result;
			WB_MEM:  wb_data = mem_rd_data;
			WB_PC:   wb_data = pc_next; // pcs never branches so this is pc+2.
			WB_BYTE: wb_data = byte_merge;
			default: wb_data = alu_result;
		endcase
	end

	assign full_flags = (opcode == OP_ADD) || (opcode == OP_SUB);

	always_comb begin
		flags_d         = flags_q;
		flags_d[FLAG_Z] = alu_flags[FLAG_Z];
		if (full_flags) begin
			flags_d[FLAG_V] = alu_flags[FLAG_V];
			flags_d[FLAG_N] = alu_flags[FLAG_N];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q    <= '0;
			flags_q <= '0;
		end else begin
			pc_q <= pc_next;
			if (flag_wr && run) begin
				flags_q <= flags_d;
			end
		end
	end

	assign wb_en_o   = reg_wr & run & (rd_addr != '0);
	assign wb_addr_o = rd_addr;
	assign wb_data_o = wb_data;
	assign pc_o      = pc_next;
	assign halt_o    = dec_halt;

endmodule

`default_nettype wire

/* cpu_data_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_data_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_addr_t;
	typedef logic [`CPU_MEM_AW-1:0] mem_index_t;
	typedef logic [2:0] flags_t; // z, v, n from msb down.

	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

endpackage

`default_nettype wire

/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath width, also the byte-address width.
`define CPU_WORD_W 16

// general purpose registers.
`define CPU_REG_CNT 16

// word index, taken from address bits 8:1.
`define CPU_MEM_AW 8

// words in each memory.
`define CPU_MEM_DEPTH 256

`endif

/* cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	typedef enum logic [3:0] {
		OP_ADD   = 4'b0000,
		OP_SUB   = 4'b0001,
		OP_XOR   = 4'b0010,
		OP_RSV_A = 4'b0011,
		OP_SRA   = 4'b0100,
		OP_SLL   = 4'b0101,
		OP_ROR   = 4'b0110,
		OP_RSV_B = 4'b0111,
		OP_LW    = 4'b1000,
		OP_SW    = 4'b1001,
		OP_LHB   = 4'b1010,
		OP_LLB   = 4'b1011,
		OP_B     = 4'b1100,
		OP_BR    = 4'b1101,
		OP_PCS   = 4'b1110,
		OP_HLT   = 4'b1111
	} opcode_e;

	typedef enum logic [2:0] {
		COND_NE = 3'b000,
		COND_EQ = 3'b001,
		COND_GT = 3'b010,
		COND_LT = 3'b011,
		COND_GE = 3'b100,
		COND_LE = 3'b101,
		COND_OV = 3'b110,
		COND_UN = 3'b111
	} cond_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC,
		WB_BYTE
	} wb_sel_e;

	// field positions in the instruction word.
	localparam int OPCODE_LSB = 12;
	localparam int RD_LSB     = 8;
	localparam int COND_LSB   = 9;
	localparam int RS_LSB     = 4;
	localparam int RT_LSB     = 0;

	typedef logic [8:0] br_offset_t;
	typedef logic [7:0] imm_byte_t;
	typedef logic [3:0] imm_nib_t;

endpackage

`default_nettype wire

/* cpu_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_memory
	import cpu_data_pkg::*;
(
	input  logic       clk,
	input  logic       wr_en_i,
	input  mem_index_t addr_i,
	input  word_t      wr_data_i,
	output word_t      rd_data_o
);

	word_t mem [`CPU_MEM_DEPTH];

	assign rd_data_o = mem[addr_i]; // async read.

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem[addr_i] <= wr_data_i;
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
cpu_data_pkg.sv
cpu_isa_pkg.sv
pc_control.sv
register_file.sv
alu_compute.sv
cpu_memory.sv
instruction_decode.sv
cpu.sv
tb_cpu_assertions.sv
tb_cpu.sv

/* instruction_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module instruction_decode
	import cpu_data_pkg::*;
	import cpu_isa_pkg::*;
(
	input  word_t      instr_i,
	output opcode_e    opcode_o,
	output cond_e      cond_o,
	output reg_addr_t  rs_addr_o,
	output reg_addr_t  rt_addr_o,
	output reg_addr_t  rd_addr_o,
	output word_t      imm_o,
	output imm_byte_t  byte_o,
	output br_offset_t offset_o,
	output logic       use_imm_o,
	output logic       reg_wr_o,
	output logic       mem_wr_o,
	output logic       flag_wr_o,
	output logic       halt_o,
	output wb_sel_e    wb_sel_o
);

	localparam int RA_W = $bits(reg_addr_t);

	opcode_e   opcode;
	reg_addr_t rd_field;
	reg_addr_t rs_field;
	reg_addr_t rt_field;
	imm_nib_t  imm_field;

	assign opcode    = opcode_e'(instr_i[OPCODE_LSB +: $bits(opcode_e)]);
	assign rd_field  = instr_i[RD_LSB +: RA_W];
	assign rs_field  = instr_i[RS_LSB +: RA_W];
	assign rt_field  = instr_i[RT_LSB +: RA_W];
	assign imm_field = instr_i[RT_LSB +: $bits(imm_nib_t)];

	assign opcode_o  = opcode;
	assign cond_o    = cond_e'(instr_i[COND_LSB +: $bits(cond_e)]);
	assign rd_addr_o = rd_field;
	assign rs_addr_o = ((opcode == OP_LHB) || (opcode == OP_LLB)) ? rd_field : rs_field;
	assign rt_addr_o = (opcode == OP_SW) ? rd_field : rt_field; // sw reads its store data here.
	assign imm_o     = {{(`CPU_WORD_W-$bits(imm_nib_t)){imm_field[$bits(imm_nib_t)-1]}},
		imm_field};
	assign byte_o    = instr_i[$bits(imm_byte_t)-1:0];
	assign offset_o  = instr_i[$bits(br_offset_t)-1:0];

	always_comb begin
		use_imm_o = 1'b0;
		reg_wr_o  = 1'b0;
		mem_wr_o  = 1'b0;
		flag_wr_o = 1'b0;
		halt_o    = 1'b0;
		wb_sel_o  = WB_ALU;
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR: begin
				reg_wr_o  = 1'b1;
				flag_wr_o = 1'b1;
			end
			OP_SRA, OP_SLL, OP_ROR: begin
				reg_wr_o  = 1'b1;
				flag_wr_o = 1'b1;
				use_imm_o = 1'b1; // shift amount.
			end
			OP_LW: begin
				reg_wr_o  = 1'b1;
				use_imm_o = 1'b1;
				wb_sel_o  = WB_MEM;
			end
			OP_SW: begin
				mem_wr_o  = 1'b1;
				use_imm_o = 1'b1;
			end
			OP_LHB, OP_LLB: begin
				reg_wr_o = 1'b1;
				wb_sel_o = WB_BYTE;
			end
			OP_PCS: begin
				reg_wr_o = 1'b1;
				wb_sel_o = WB_PC;
			end
			OP_HLT: halt_o = 1'b1;
			default: ; // branches and reserved codes write nothing.
		endcase
	end

endmodule

`default_nettype wire

/* pc_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module pc_control
	import cpu_data_pkg::*;
	import cpu_isa_pkg::*;
(
	input  word_t      pc_i,
	input  word_t      rs_data_i,
	input  br_offset_t offset_i,
	input  opcode_e    opcode_i,
	input  cond_e      cond_i,
	input  flags_t     flags_i,
	output word_t      pc_next_o
);

	logic  flag_z;
	logic  flag_v;
	logic  flag_n;
	logic  cond_met;
	word_t pc_plus2;
	word_t offset_ext;
	word_t rel_target;

	assign flag_z = flags_i[FLAG_Z];
	assign flag_v = flags_i[FLAG_V];
	assign flag_n = flags_i[FLAG_N];

	assign pc_plus2   = pc_i + word_t'(2);
	assign offset_ext = {{(`CPU_WORD_W-$bits(br_offset_t)){offset_i[$bits(br_offset_t)-1]}},
		offset_i};
	assign rel_target = pc_plus2 + (offset_ext << 1); // offset counts words.

	always_comb begin
		case (cond_i)
			COND_NE: cond_met = ~flag_z;
			COND_EQ: cond_met = flag_z;
			COND_GT: cond_met = ~flag_z & ~flag_n;
			COND_LT: cond_met = flag_n;
			COND_GE: cond_met = (~flag_z & ~flag_n) | flag_z;
			COND_LE: cond_met = flag_n | flag_z;
			COND_OV: cond_met = flag_v;
			COND_UN: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode_i)
			OP_B:    pc_next_o = cond_met ? rel_target : pc_plus2;
			OP_BR:   pc_next_o = cond_met ? rs_data_i : pc_plus2;
			OP_HLT:  pc_next_o = pc_i; // stay on the halt.
			default: pc_next_o = pc_plus2;
		endcase
	end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module register_file
	import cpu_data_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n_i,
	input  reg_addr_t rs_addr_i,
	input  reg_addr_t rt_addr_i,
	input  reg_addr_t rd_addr_i,
	input  logic      wr_en_i,
	input  word_t     rd_data_i,
	output word_t     rs_data_o,
	output word_t     rt_data_o
);

	word_t regs [`CPU_REG_CNT];

	assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
	assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && (rd_addr_i != '0)) begin
			regs[rd_addr_i] <= rd_data_i; // r0 is never written.
		end
	end

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu
	import cpu_data_pkg::*;
	import cpu_isa_pkg::*;
();

	localparam int    TIMEOUT_CYCLES = 2000; // about four times the summed test lengths.
	localparam word_t NOP_A_WORD     = {OP_RSV_A, 4'hf, 8'h21};
	localparam word_t NOP_B_WORD     = {OP_RSV_B, 4'hf, 8'h21};
	localparam word_t HLT_WORD       = {OP_HLT, 12'h000};

	logic      clk;
	logic      rst_n_i;
	logic      imem_wr_en_i;
	word_t     imem_addr_i;
	word_t     imem_data_i;
	word_t     pc_o;
	logic      halt_o;
	logic      wb_en_o;
	reg_addr_t wb_addr_o;
	word_t     wb_data_o;

	integer    seed;
	int        cycles = 0;
	word_t     prog[$];
	reg_addr_t exp_addr[$];
	word_t     exp_data[$];
	reg_addr_t tr_addr[$];
	word_t     tr_data[$];
	word_t     tr_pc[$];
	int        tr_step[$];
	word_t     model_regs[`CPU_REG_CNT];
	logic      mz;
	logic      mv;
	logic      mn;
	word_t     halt_pc;

	cpu cpu_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.imem_wr_en_i (imem_wr_en_i),
		.imem_addr_i  (imem_addr_i),
		.imem_data_i  (imem_data_i),
		.pc_o         (pc_o),
		.halt_o       (halt_o),
		.wb_en_o      (wb_en_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the processor did not reach halt within %0d cycles.",
				TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic fail_now(string msg);
		$display("[FAIL] %0t %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_write(reg_addr_t rd, word_t v);
		model_regs[rd] = v;
		exp_addr.push_back(rd);
		exp_data.push_back(v);
	endtask

	task automatic start_program();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		model_regs = '{default: '0};
		mz = 1'b0;
		mv = 1'b0;
		mn = 1'b0;
		prog.push_back(NOP_A_WORD); // reserved code, runs before the trace starts.
	endtask

	task automatic byte_load(opcode_e op, reg_addr_t rd, logic [7:0] b);
		word_t old;
		old = model_regs[rd];
		prog.push_back({op, rd, b});
		expect_write(rd, (op == OP_LHB) ? {b, old[7:0]} : {old[15:8], b});
	endtask

	task automatic load_const(reg_addr_t rd, word_t v);
		byte_load(OP_LLB, rd, v[7:0]);
		byte_load(OP_LHB, rd, v[15:8]);
	endtask

	task automatic alu_op(opcode_e op, reg_addr_t rd, reg_addr_t rs, logic [3:0] rt);
		word_t a;
		word_t b;
		word_t r;
		int    wide;
		int    sh;
		a    = model_regs[rs];
		b    = model_regs[rt];
		sh   = int'(rt);
		wide = 0;
		r    = '0;
		case (op)
			OP_ADD:  wide = int'($signed(a)) + int'($signed(b));
			OP_SUB:  wide = int'($signed(a)) - int'($signed(b));
			OP_XOR:  r = a ^ b;
			OP_SRA:  r = word_t'($signed(a) >>> sh);
			OP_SLL:  r = a << sh;
			default: r = (a >> sh) | (a << (16 - sh)); // rotate right.
		endcase
		if ((op == OP_ADD) || (op == OP_SUB)) begin
			mv = (wide > 32767) || (wide < -32768);
			if (wide > 32767) begin
				wide = 32767;
			end else if (wide < -32768) begin
				wide = -32768;
			end
			r  = word_t'(wide);
			mn = r[15];
		end
		mz = (r == 16'h0000);
		prog.push_back({op, rd, rs, rt});
		expect_write(rd, r);
	endtask

	function automatic bit branch_taken(cond_e c);
		case (c)
			COND_NE: return !mz;
			COND_EQ: return mz;
			COND_GT: return !mz && !mn;
			COND_LT: return mn;
			COND_GE: return (!mz && !mn) || mz;
			COND_LE: return mn || mz;
			COND_OV: return mv;
			default: return 1'b1;
		endcase
	endfunction

	task automatic load_and_run();
		int n;
		int step;
		bit done;
		n    = (prog.size() > 5) ? prog.size() : 5;
		step = 0;
		done = 1'b0;
		tr_addr.delete();
		tr_data.delete();
		tr_pc.delete();
		tr_step.delete();
		@(negedge clk);
		rst_n_i = 1'b0;
		for (int i = 0; i < n; i++) begin
			imem_wr_en_i = (i < prog.size());
			imem_addr_i  = word_t'(2 * i);
			imem_data_i  = (i < prog.size()) ? prog[i] : 16'h0000;
			@(negedge clk);
		end
		imem_wr_en_i = 1'b0;
		rst_n_i      = 1'b1;
		// word 0 runs in the release half cycle, sampling starts at word 1.
		while (!done) begin
			@(negedge clk);
			step++;
			if (wb_en_o) begin
				tr_addr.push_back(wb_addr_o);
				tr_data.push_back(wb_data_o);
				tr_pc.push_back(pc_o);
				tr_step.push_back(step);
			end
			done    = halt_o;
			halt_pc = pc_o;
		end
	endtask

	task automatic run_and_check(string name);
		load_and_run();
		assert (tr_data.size() == exp_data.size()) else
			fail_now($sformatf("%s: %0d write-backs, expected %0d", name, tr_data.size(),
				exp_data.size()));
		foreach (exp_data[i]) begin
			assert ((tr_addr[i] == exp_addr[i]) && (tr_data[i] == exp_data[i])) else
				fail_now($sformatf("%s: write %0d is r%0d=%h, expected r%0d=%h", name, i,
					tr_addr[i], tr_data[i], exp_addr[i], exp_data[i]));
		end
	endtask

	task automatic build_constants();
		start_program();
		for (int r = 1; r < 8; r++) begin
			load_const(reg_addr_t'(r), word_t'($random(seed)));
		end
		prog.push_back(HLT_WORD);
		run_and_check("byte loads");
		foreach (tr_step[i]) begin
			assert (tr_step[i] == i + 1) else
				fail_now($sformatf("byte loads: write %0d came in cycle %0d, expected %0d",
					i, tr_step[i], i + 1));
		end
	endtask

	task automatic alu_results();
		start_program();
		load_const(4'd1, word_t'($random(seed)));
		load_const(4'd2, word_t'($random(seed)));
		load_const(4'd3, 16'h7000);
		load_const(4'd4, 16'h5000);
		load_const(4'd5, 16'h9000);
		alu_op(OP_ADD, 4'd6, 4'd1, 4'd2);
		alu_op(OP_SUB, 4'd7, 4'd1, 4'd2);
		alu_op(OP_XOR, 4'd8, 4'd1, 4'd2);
		alu_op(OP_ADD, 4'd9, 4'd3, 4'd4); // clamps to 7fff.
		alu_op(OP_SUB, 4'd10, 4'd5, 4'd3); // clamps to 8000.
		alu_op(OP_ADD, 4'd14, 4'd5, 4'd5);
		prog.push_back(NOP_A_WORD); // reserved codes write nothing.
		prog.push_back(NOP_B_WORD);
		for (int k = 0; k < 3; k++) begin
			alu_op(OP_SRA, 4'd11, 4'd1, 4'($random(seed)));
			alu_op(OP_SLL, 4'd12, 4'd2, 4'($random(seed)));
			alu_op(OP_ROR, 4'd13, 4'd1, 4'($random(seed)));
		end
		prog.push_back(HLT_WORD);
		run_and_check("alu");
	endtask

	task automatic store_and_load();
		word_t base;
		base = word_t'($random(seed));
		start_program();
		load_const(4'd1, base);
		load_const(4'd2, word_t'($random(seed)));
		load_const(4'd3, word_t'($random(seed)));
		load_const(4'd6, {base[15:1], 1'b0} + 16'd6); // same word as r1 plus 3 words.
		prog.push_back({OP_SW, 4'd2, 4'd1, 4'd3});
		prog.push_back({OP_SW, 4'd3, 4'd1, 4'hb}); // minus 5 words.
		prog.push_back({OP_LW, 4'd4, 4'd1, 4'd3});
		expect_write(4'd4, model_regs[2]);
		prog.push_back({OP_LW, 4'd5, 4'd1, 4'hb});
		expect_write(4'd5, model_regs[3]);
		prog.push_back({OP_LW, 4'd7, 4'd6, 4'd0});
		expect_write(4'd7, model_regs[2]);
		prog.push_back(HLT_WORD);
		run_and_check("load store");
	endtask

	task automatic branch_conditions();
		bit taken;
		start_program();
		load_const(4'd1, {1'b0, 15'($random(seed))} | 16'h0001);
		load_const(4'd2, {1'b1, 15'($random(seed))});
		load_const(4'd3, 16'h7fff);
		for (int c = 0; c < 8; c++) begin
			for (int s = 0; s < 4; s++) begin
				case (s)
					0:       alu_op(OP_SUB, 4'd5, 4'd1, 4'd1); // zero.
					1:       alu_op(OP_ADD, 4'd5, 4'd1, 4'd0); // positive.
					2:       alu_op(OP_ADD, 4'd5, 4'd2, 4'd0); // negative.
					default: alu_op(OP_ADD, 4'd5, 4'd3, 4'd3); // overflow.
				endcase
				taken = branch_taken(cond_e'(c));
				prog.push_back({OP_B, 3'(c), 9'd1}); // skips one word.
				prog.push_back({OP_LLB, 4'd14, 8'(c * 4 + s)});
				if (!taken) begin
					expect_write(4'd14, {model_regs[14][15:8], 8'(c * 4 + s)});
				end
				byte_load(OP_LLB, 4'd15, 8'(c * 4 + s));
			end
		end
		prog.push_back(HLT_WORD);
		run_and_check("branches");
	endtask

	task automatic jump_and_pcs();
		word_t pcs_a;
		word_t pcs_b;
		start_program();
		byte_load(OP_LLB, 4'd1, 8'd10); // word 5 holds the first pcs.
		prog.push_back({OP_BR, COND_UN, 1'b0, 4'd1, 4'd0});
		prog.push_back({OP_LLB, 4'd2, 8'h55});
		prog.push_back({OP_LLB, 4'd2, 8'h66});
		pcs_a = word_t'(2 * prog.size() + 2);
		prog.push_back({OP_PCS, 4'd3, 8'h00});
		expect_write(4'd3, pcs_a);
		alu_op(OP_SUB, 4'd4, 4'd1, 4'd1);
		prog.push_back({OP_BR, COND_NE, 1'b0, 4'd1, 4'd0}); // z is set, falls through.
		pcs_b = word_t'(2 * prog.size() + 2);
		prog.push_back({OP_PCS, 4'd5, 8'h00});
		expect_write(4'd5, pcs_b);
		prog.push_back(HLT_WORD);
		run_and_check("br and pcs");
		assert ((tr_pc[1] == pcs_a) && (tr_pc[3] == pcs_b)) else
			fail_now($sformatf("pcs: pc_o was %h and %h, expected %h and %h", tr_pc[1], tr_pc[3],
				pcs_a, pcs_b));
	endtask

	task automatic halt_hold();
		word_t hlt_addr;
		start_program();
		byte_load(OP_LLB, 4'd1, 8'h5a);
		hlt_addr = word_t'(2 * prog.size());
		prog.push_back(HLT_WORD);
		prog.push_back({OP_LLB, 4'd2, 8'ha5}); // past the halt.
		run_and_check("halt");
		assert (halt_pc == hlt_addr) else
			fail_now($sformatf("halt: pc_o is %h, expected %h", halt_pc, hlt_addr));
		repeat (10) begin
			@(negedge clk);
			assert (halt_o && (pc_o == hlt_addr) && !wb_en_o) else
				fail_now($sformatf("halt: halt_o=%b pc_o=%h wb_en_o=%b", halt_o, pc_o, wb_en_o));
		end
	endtask

	initial begin
		int bound_fails;
		seed         = 32'h4552_fe7f;
		rst_n_i      = 1'b0;
		imem_wr_en_i = 1'b0;
		imem_addr_i  = '0;
		imem_data_i  = '0;
		build_constants();
		alu_results();
		store_and_load();
		branch_conditions();
		jump_and_pcs();
		halt_hold();
		bound_fails = cpu_i.cpu_assertions_i.reset_fails + cpu_i.cpu_assertions_i.halt_fails +
			cpu_i.cpu_assertions_i.r0_fails;
		if (bound_fails == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("%0d bound assertion failures in the processor.", bound_fails);
			$display("Simulation FAILED");
			$fatal(1, "run stopped by failed bound assertions");
		end
	end

endmodule

`default_nettype wire

/* tb_cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_assertions
	import cpu_data_pkg::*;
(
	input logic      clk_i,
	input logic      rst_n_i,
	input logic      halt_i,
	input word_t     pc_i,
	input logic      wb_en_i,
	input reg_addr_t wb_addr_i
);

	int reset_fails = 0;
	int halt_fails  = 0;
	int r0_fails    = 0;

	no_write_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_en_i)
		else begin
			reset_fails++;
			$error("register write strobe active while reset is held");
		end

	// halt keeps pc and halt until the next reset.
	pc_held_on_halt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		halt_i |=> (halt_i && $stable(pc_i)))
		else begin
			halt_fails++;
			$error("pc or halt changed after a halt");
		end

	no_write_to_r0: assert property (@(posedge clk_i) wb_en_i |-> (wb_addr_i != '0))
		else begin
			r0_fails++;
			$error("register write strobe aimed at register zero");
		end

endmodule

bind cpu tb_cpu_assertions cpu_assertions_i (
	.clk_i     (clk),
	.rst_n_i   (rst_n_i),
	.halt_i    (halt_o),
	.pc_i      (pc_o),
	.wb_en_i   (wb_en_o),
	.wb_addr_i (wb_addr_o)
);

`default_nettype wire
